// File: Makefile
# Verilator simulation of the DDS scope testbench

VERILATOR ?= verilator
TOP       ?= tb_dds_scope
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# build, run, and decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+dv
hw/dds_pkg.sv
hw/wave_bus_if.sv
hw/key_event_decoder.sv
hw/dds_waveform_gen.sv
hw/keying_modulator.sv
hw/scope_sampler.sv
hw/dds_scope_top.sv
dv/tb_dds_scope.sv

// File: dv/tb_dds_scope_tasks.svh
////////////////////
// checks and waits

task automatic check_equal(input logic [63:0] got, input logic [63:0] expected,
                           input string what);
   if (got !== expected)
   begin
      $display("ERR @ %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, expected);
      $display("TB FAILED");
      $fatal(1, "stopped at first mismatch");
   end
endtask

task automatic fail_run(input string why);
   $display("%s", why);
   $display("TB FAILED");
   $fatal(1, "run aborted");
endtask

// returns the number of falling edges until the strobe shows
task automatic wait_sample(output int cycles);
   logic seen;
   seen = 1'b0;
   cycles = 0;
   while (!seen && cycles < 4 * dds_pkg::SAMPLE_TICK_DIV)
   begin
      @(negedge CLK_25MHZ);
      cycles++;
      seen = sample_valid;
   end
   if (!seen)
   begin
      fail_run("no sample_valid pulse arrived within four sample periods");
   end
endtask

task automatic apply_settings(input logic wave, input logic [1:0] mode,
                              input logic [31:0] inc);
   int cycles;
   @(negedge CLK_25MHZ);
   wave_sel      = wave;
   mod_sel       = mode;
   dds_increment = inc;
   wait_sample(cycles);   // this one straddles the change
endtask

task automatic send_key_event(input logic [7:0] ev);
   @(negedge CLK_25MHZ);
   key_event_valid = 1'b1;
   key_event       = ev;
   @(negedge CLK_25MHZ);
   key_event_valid = 1'b0;
   key_event       = '0;
   held_model = next_held_keys(held_model, ev);
   check_equal(held_keys, held_model, "held_keys after key event");
endtask

////////////////////
// directed tests

task automatic test_reset_state();
   int cycles;
   check_equal({held_keys, signal_sample, modulated_sample, lfsr_sample, sample_valid}, '0,
               "outputs after reset");
   wait_sample(cycles);
   check_equal(cycles, dds_pkg::SAMPLE_TICK_DIV, "cycles from reset release to first sample");
   wait_sample(cycles);
   check_equal(cycles, dds_pkg::SAMPLE_TICK_DIV, "cycles between samples");
endtask

task automatic test_key_tracking();
   logic [31:0] r;
   logic [7:0]  ev;
   for (int i = 0; i < 48; i++)
   begin
      r  = rand_bits(6);   // break flag and key code
      ev = {r[5], 2'b00, 5'(r[4:0] % 5'd17)};
      send_key_event(ev);
      if (i % 6 == 5)
      begin
         // reserved bits set so taking it would flip the key
         send_key_event({~ev[7], 2'b01 + 2'((i / 6) % 3), ev[4:0]});
      end
   end
   send_key_event(8'h11);   // code 17 is past the last key
   send_key_event(8'h1f);
endtask

task automatic test_saw_and_square();
   int          cycles;
   logic [11:0] prev;
   logic        seen_pos;
   logic        seen_neg;
   apply_settings(dds_pkg::WAVE_SAW, dds_pkg::MOD_NONE, 32'(SAW_K) << 20);
   wait_sample(cycles);
   prev = signal_sample;
   repeat (20)
   begin
      wait_sample(cycles);
      check_equal(12'(signal_sample - prev), 12'(dds_pkg::SAMPLE_TICK_DIV * SAW_K),
                  "saw step between samples");
      check_equal(modulated_sample, signal_sample, "modulated sample with no keying");
      prev = signal_sample;
   end
   apply_settings(dds_pkg::WAVE_SQUARE, dds_pkg::MOD_NONE, 32'(SQUARE_K) << 20);
   seen_pos = 1'b0;
   seen_neg = 1'b0;
   repeat (40)
   begin
      wait_sample(cycles);
      seen_pos = seen_pos | (signal_sample == 12'h7ff);
      seen_neg = seen_neg | (signal_sample == 12'h800);
      check_equal((signal_sample == 12'h7ff) || (signal_sample == 12'h800), 1'b1,
                  "square sample on a rail");
      check_equal(modulated_sample, signal_sample, "modulated sample with no keying");
   end
   check_equal({seen_pos, seen_neg}, 2'b11, "square reached both rails");
endtask

task automatic check_keying(input logic [1:0] mode, input logic wave);
   int   cycles;
   logic seen_high;
   logic seen_low;
   apply_settings(wave, mode, 32'(SAW_K) << 20);
   seen_high = 1'b0;
   seen_low  = 1'b0;
   repeat (150)   // spans several lfsr steps
   begin
      wait_sample(cycles);
      check_equal(modulated_sample, keyed_sample(mode, signal_sample, lfsr_sample[0]),
                  "keyed sample");
      seen_high = seen_high | lfsr_sample[0];
      seen_low  = seen_low | ~lfsr_sample[0];
   end
   check_equal({seen_high, seen_low}, 2'b11, "both keying states sampled");
endtask

task automatic test_ask_bpsk();
   check_keying(dds_pkg::MOD_ASK, dds_pkg::WAVE_SAW);
   check_keying(dds_pkg::MOD_BPSK, dds_pkg::WAVE_SAW);
   check_keying(dds_pkg::MOD_BPSK, dds_pkg::WAVE_SQUARE);   // hits the -2048 corner
endtask

task automatic test_lfsr_sequence();
   int         cycles;
   int         steps;
   logic [4:0] first;
   logic [4:0] prev;
   wait_sample(cycles);
   first = lfsr_sample;
   check_equal(first != 5'd0, 1'b1, "lfsr state nonzero");
   prev  = first;
   steps = 0;
   for (int n = 0; n < 800 && steps < 35; n++)
   begin
      wait_sample(cycles);
      if (lfsr_sample != prev)
      begin
         steps++;
         check_equal(lfsr_sample, lfsr_after(prev), "lfsr step");
         check_equal(lfsr_sample == first, steps % 31 == 0, "lfsr period of 31");
         prev = lfsr_sample;
      end
   end
   if (steps < 35)
   begin
      fail_run("lfsr_sample stopped changing before 35 steps were seen");
   end
endtask

task automatic test_fsk();
   int          cycles;
   logic [11:0] prev;
   logic [4:0]  prev_lfsr;
   logic        seen_high;
   logic        seen_low;
   apply_settings(dds_pkg::WAVE_SAW, dds_pkg::MOD_FSK, 32'(SAW_K) << 20);
   wait_sample(cycles);
   prev      = signal_sample;
   prev_lfsr = lfsr_sample;
   seen_high = 1'b0;
   seen_low  = 1'b0;
   repeat (200)
   begin
      wait_sample(cycles);
      if (lfsr_sample == prev_lfsr)   // one tone across the whole pair
      begin
         check_equal(12'(signal_sample - prev) == 12'(dds_pkg::SAMPLE_TICK_DIV * SAW_K),
                     lfsr_sample[0], "fsk saw step against lfsr bit 0");
         seen_high = seen_high | lfsr_sample[0];
         seen_low  = seen_low | ~lfsr_sample[0];
      end
      prev      = signal_sample;
      prev_lfsr = lfsr_sample;
   end
   check_equal({seen_high, seen_low}, 2'b11, "both fsk tones sampled");
endtask

// File: dv/tb_dds_scope.sv
`timescale 1ns/1ps

module tb_dds_scope;

   localparam int SAW_K    = 3;    // saw increment in units of 2^20
   localparam int SQUARE_K = 40;

   logic        CLK_25MHZ;
   logic        reset_from_key;
   logic        key_event_valid;
   logic [7:0]  key_event;
   logic        wave_sel;
   logic [1:0]  mod_sel;
   logic [31:0] dds_increment;
   logic [16:0] held_keys;
   logic        sample_valid;
   logic [11:0] signal_sample;
   logic [11:0] modulated_sample;
   logic [4:0]  lfsr_sample;

   logic [31:0] rng_state;    // galois lfsr for stimulus
   logic [16:0] held_model;   // expected key bitmap

   dds_scope_top dut (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .key_event_valid  (key_event_valid),
      .key_event        (key_event),
      .wave_sel         (wave_sel),
      .mod_sel          (mod_sel),
      .dds_increment    (dds_increment),
      .held_keys        (held_keys),
      .sample_valid     (sample_valid),
      .signal_sample    (signal_sample),
      .modulated_sample (modulated_sample),
      .lfsr_sample      (lfsr_sample)
   );

   always #20 CLK_25MHZ = ~CLK_25MHZ;   // 40 ns period

   ////////////////////
   // reference models

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int count);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < count; i++)
      begin
         rng_state = rng_state[0] ? (rng_state >> 1) ^ 32'hd0000001 : rng_state >> 1;
         bits = {bits[30:0], rng_state[0]};
      end
      return bits;
   endfunction

   // make sets, break clears, malformed or unknown codes are dropped
   function automatic logic [16:0] next_held_keys(input logic [16:0] keys,
                                                  input logic [7:0] ev);
      logic [16:0] result;
      result = keys;
      if (ev[6:5] == 2'b00 && ev[4:0] < 5'd17)
      begin
         result[ev[4:0]] = ~ev[7];
      end
      return result;
   endfunction

   function automatic logic [4:0] lfsr_after(input logic [4:0] state);
      return {state[3:0], state[4] ^ state[2]};   // taps 4 and 2 into bit 0
   endfunction

   function automatic logic [11:0] keyed_sample(input logic [1:0] mode,
                                                input logic [11:0] sig,
                                                input logic key_bit);
      logic [11:0] result;
      result = sig;
      if (!key_bit && mode == dds_pkg::MOD_ASK)
      begin
         result = 12'd0;
      end
      else if (!key_bit && mode == dds_pkg::MOD_BPSK)
      begin
         result = 12'd0 - sig;   // negation mod 4096
      end
      return result;
   endfunction

   `include "tb_dds_scope_tasks.svh"

   ////////////////////
   // test sequence

   initial
   begin
      CLK_25MHZ       = 1'b0;
      reset_from_key  = 1'b1;
      key_event_valid = 1'b0;
      key_event       = '0;
      wave_sel        = 1'b0;
      mod_sel         = 2'b00;
      dds_increment   = '0;
      rng_state       = 32'hab2c63f1;
      held_model      = '0;
      repeat (2) @(negedge CLK_25MHZ);
      reset_from_key = 1'b0;
      test_reset_state();
      test_key_tracking();
      test_saw_and_square();
      test_ask_bpsk();
      test_lfsr_sequence();
      test_fsk();
      $display("TB PASSED");
      $finish;
   end

endmodule

// File: hw/dds_pkg.sv
package dds_pkg;

   ////////////////////
   // widths

   localparam int PHASE_W     = 32;
   localparam int SAMPLE_W    = 12;   // signed two's complement
   localparam int LFSR_W      = 5;
   localparam int KEY_COUNT   = 17;
   localparam int KEY_EVENT_W = 8;
   localparam int KEY_ID_W    = 5;
   localparam int KEY_BREAK_BIT = 7;  // 1 = key released

   ////////////////////
   // dividers and seeds

   localparam int LFSR_TICK_DIV   = 1000;  // cycles per lfsr step
   localparam int SAMPLE_TICK_DIV = 50;    // cycles per scope sample
   localparam int LFSR_TICK_W     = $clog2(LFSR_TICK_DIV);
   localparam int SAMPLE_TICK_W   = $clog2(SAMPLE_TICK_DIV);

   localparam logic [LFSR_W-1:0]  LFSR_SEED      = 5'd1;
   localparam logic [PHASE_W-1:0] BASE_PHASE_INC = 32'd258;  // fsk low tone

   typedef logic [PHASE_W-1:0]         phase_t;
   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic [LFSR_W-1:0]          lfsr_t;
   typedef logic [LFSR_TICK_W-1:0]     lfsr_tick_t;
   typedef logic [SAMPLE_TICK_W-1:0]   sample_tick_t;

   // square wave rails, full scale
   localparam sample_t WAVE_POS_PEAK = {1'b0, {(SAMPLE_W-1){1'b1}}};  // +2047
   localparam sample_t WAVE_NEG_PEAK = {1'b1, {(SAMPLE_W-1){1'b0}}};  // -2048

   ////////////////////
   // enums

   typedef enum logic {
      WAVE_SQUARE,
      WAVE_SAW
   } wave_kind_t;

   typedef enum logic [1:0] {
      MOD_NONE,
      MOD_ASK,
      MOD_BPSK,
      MOD_FSK
   } mod_kind_t;

   // bit position in the held-key bitmap
   typedef enum logic [KEY_ID_W-1:0] {
      KEY_DOWN, KEY_UP, KEY_RIGHT, KEY_LEFT, KEY_SPACE,
      KEY_M, KEY_N, KEY_F2, KEY_F1,
      KEY_8, KEY_7, KEY_6, KEY_5, KEY_4, KEY_3, KEY_2, KEY_1
   } key_id_t;

endpackage

// File: hw/dds_scope_top.sv
`timescale 1ns/1ps

module dds_scope_top (
   input  logic                              CLK_25MHZ,
   input  logic                              reset_from_key,
   input  logic                              key_event_valid,
   input  logic [dds_pkg::KEY_EVENT_W-1:0]   key_event,
   input  logic                              wave_sel,
   input  logic [1:0]                        mod_sel,
   input  logic [dds_pkg::PHASE_W-1:0]       dds_increment,
   output logic [dds_pkg::KEY_COUNT-1:0]     held_keys,
   output logic                              sample_valid,
   output logic [dds_pkg::SAMPLE_W-1:0]      signal_sample,
   output logic [dds_pkg::SAMPLE_W-1:0]      modulated_sample,
   output logic [dds_pkg::LFSR_W-1:0]        lfsr_sample
);

   dds_pkg::wave_kind_t wave_kind;
   dds_pkg::mod_kind_t  mod_kind;

   // raw select bits onto the enums
   assign wave_kind = dds_pkg::wave_kind_t'(wave_sel);
   assign mod_kind  = dds_pkg::mod_kind_t'(mod_sel);

   wave_bus_if wave_bus ();

   ////////////////////
   // key tracking

   key_event_decoder u_key_event_decoder (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_valid (key_event_valid),
      .key_event       (key_event),
      .held_keys       (held_keys)
   );

   ////////////////////
   // tone and keying

   dds_waveform_gen u_dds_waveform_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .dds_increment  (dds_increment),
      .mod_sel        (mod_kind),
      .wave           (wave_bus.dds)
   );

   keying_modulator u_keying_modulator (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .wave_sel       (wave_kind),
      .mod_sel        (mod_kind),
      .wave           (wave_bus.modulator)
   );

   // scope capture
   scope_sampler u_scope_sampler (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .wave             (wave_bus.sampler),
      .sample_valid     (sample_valid),
      .signal_sample    (signal_sample),
      .modulated_sample (modulated_sample),
      .lfsr_sample      (lfsr_sample)
   );

endmodule

// File: hw/dds_waveform_gen.sv
`timescale 1ns/1ps

module dds_waveform_gen (
   input  logic                         CLK_25MHZ,
   input  logic                         reset_from_key,
   input  logic [dds_pkg::PHASE_W-1:0]  dds_increment,
   input  dds_pkg::mod_kind_t           mod_sel,
   wave_bus_if.dds                      wave
);

   dds_pkg::phase_t phase;
   dds_pkg::phase_t phase_inc;

   // fsk toggles between the input tone and the fixed base tone
   always_comb
   begin
      phase_inc = dds_increment;
      if (mod_sel == dds_pkg::MOD_FSK && !wave.lfsr_state[0])
      begin
         phase_inc = dds_pkg::BASE_PHASE_INC;
      end
   end

   ////////////////////
   // phase accumulator

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase <= '0;
      end
      else
      begin
         phase <= phase + phase_inc;   // wraps mod 2^32
      end
   end

   // waves straight off the phase register
   assign wave.saw    = phase[dds_pkg::PHASE_W-1 -: dds_pkg::SAMPLE_W];
   assign wave.square = phase[dds_pkg::PHASE_W-1] ? dds_pkg::WAVE_NEG_PEAK
                                                  : dds_pkg::WAVE_POS_PEAK;

endmodule

// File: hw/key_event_decoder.sv
`timescale 1ns/1ps

module key_event_decoder (
   input  logic                               CLK_25MHZ,
   input  logic                               reset_from_key,
   input  logic                               key_event_valid,
   input  logic [dds_pkg::KEY_EVENT_W-1:0]    key_event,
   output logic [dds_pkg::KEY_COUNT-1:0]      held_keys
);

   dds_pkg::key_id_t key_id;
   logic             key_break;
   logic             key_known;

   ////////////////////
   // event fields

   assign key_id    = dds_pkg::key_id_t'(key_event[dds_pkg::KEY_ID_W-1:0]);
   assign key_break = key_event[dds_pkg::KEY_BREAK_BIT];

   // reserved bits must be clear and the code must name a tracked key
   always_comb
   begin
      key_known = 1'b1;
      if (key_event[6:5] != 2'b00)
      begin
         key_known = 1'b0;   // malformed byte
      end
      if (int'(key_id) >= dds_pkg::KEY_COUNT)
      begin
         key_known = 1'b0;
      end
   end

   ////////////////////
   // held-key bitmap

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_keys <= '0;
      end
      else if (key_event_valid && key_known)
      begin
         held_keys[key_id] <= !key_break;   // make sets, break clears
      end
   end

endmodule

// File: hw/keying_modulator.sv
`timescale 1ns/1ps

module keying_modulator (
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  dds_pkg::wave_kind_t wave_sel,
   input  dds_pkg::mod_kind_t  mod_sel,
   wave_bus_if.modulator       wave
);

   dds_pkg::lfsr_tick_t lfsr_tick_cnt;
   logic                lfsr_step;
   dds_pkg::lfsr_t      lfsr;
   dds_pkg::lfsr_t      lfsr_next;

   ////////////////////
   // slow lfsr tick

   assign lfsr_step = (lfsr_tick_cnt == dds_pkg::lfsr_tick_t'(dds_pkg::LFSR_TICK_DIV - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr_tick_cnt <= '0;
      end
      else if (lfsr_step)
      begin
         lfsr_tick_cnt <= '0;
      end
      else
      begin
         lfsr_tick_cnt <= lfsr_tick_cnt + 1'b1;
      end
   end

   // taps 4 and 2, maximal length 31
   assign lfsr_next = {lfsr[3:0], lfsr[4] ^ lfsr[2]};

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr <= dds_pkg::LFSR_SEED;   // never all zero
      end
      else if (lfsr_step)
      begin
         lfsr <= lfsr_next;
      end
   end

   assign wave.lfsr_state = lfsr;

   ////////////////////
   // wave select and keying

   assign wave.selected = (wave_sel == dds_pkg::WAVE_SQUARE) ? wave.square : wave.saw;

   always_comb
   begin
      case (mod_sel)
         dds_pkg::MOD_ASK:
         begin
            wave.modulated = lfsr[0] ? wave.selected : '0;   // on/off keying
         end
         dds_pkg::MOD_BPSK:
         begin
            wave.modulated = lfsr[0] ? wave.selected : -wave.selected;   // wraps at -2048
         end
         default:
         begin
            wave.modulated = wave.selected;   // none, and fsk keys the phase instead
         end
      endcase
   end

endmodule

// File: hw/scope_sampler.sv
`timescale 1ns/1ps

module scope_sampler (
   input  logic                          CLK_25MHZ,
   input  logic                          reset_from_key,
   wave_bus_if.sampler                   wave,
   output logic                          sample_valid,
   output logic [dds_pkg::SAMPLE_W-1:0]  signal_sample,
   output logic [dds_pkg::SAMPLE_W-1:0]  modulated_sample,
   output logic [dds_pkg::LFSR_W-1:0]    lfsr_sample
);

   dds_pkg::sample_tick_t sample_tick_cnt;
   logic                  sample_tick;

   assign sample_tick =
      (sample_tick_cnt == dds_pkg::sample_tick_t'(dds_pkg::SAMPLE_TICK_DIV - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sample_tick_cnt <= '0;
      end
      else if (sample_tick)
      begin
         sample_tick_cnt <= '0;
      end
      else
      begin
         sample_tick_cnt <= sample_tick_cnt + 1'b1;
      end
   end

   // all three on one edge so a sample matches its own lfsr state
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sample_valid     <= 1'b0;
         signal_sample    <= '0;
         modulated_sample <= '0;
         lfsr_sample      <= '0;
      end
      else
      begin
         sample_valid <= sample_tick;   // one-cycle strobe
         if (sample_tick)
         begin
            signal_sample    <= wave.selected;
            modulated_sample <= wave.modulated;
            lfsr_sample      <= wave.lfsr_state;
         end
      end
   end

endmodule

// File: hw/wave_bus_if.sv
`timescale 1ns/1ps

interface wave_bus_if;

   dds_pkg::sample_t saw;
   dds_pkg::sample_t square;
   dds_pkg::lfsr_t   lfsr_state;
   dds_pkg::sample_t selected;   // chosen wave, unmodulated
   dds_pkg::sample_t modulated;

   // phase accumulator side; lfsr bit 0 picks the fsk increment
   modport dds (
      output saw,
      output square,
      input  lfsr_state
   );

   modport modulator (
      input  saw,
      input  square,
      output lfsr_state,
      output selected,
      output modulated
   );

   modport sampler (
      input selected,
      input modulated,
      input lfsr_state
   );

endinterface
